/* alu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_pipe (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire sched_pkg::issue_t  alu_issue,
    output sched_pkg::cdb_t         alu_result,
    output sched_pkg::branch_t      alu_branch
);

    // ALU decoding of the word
    sched_pkg::alu_fields_t         f;
    logic [sched_pkg::DATA_W-1:0]   res;
    logic                           taken;
    logic                           is_branch;

    assign f         = alu_issue.instr.alu;
    assign is_branch = f.op inside {sched_pkg::BEQ, sched_pkg::BLT};

    // Arithmetic and compares
    always_comb begin
        res   = '0;
        taken = 1'b0;
        case (f.op)
            sched_pkg::ADD: res = alu_issue.a + alu_issue.b;
            sched_pkg::SUB: res = alu_issue.a - alu_issue.b;
            sched_pkg::AND: res = alu_issue.a & alu_issue.b;
            sched_pkg::XOR: res = alu_issue.a ^ alu_issue.b;
            sched_pkg::BEQ: taken = (alu_issue.a == alu_issue.b);
            // Signed compare
            sched_pkg::BLT: taken = ($signed(alu_issue.a) < $signed(alu_issue.b));
            default:        res = '0;
        endcase
    end

    // Single result register, writers to CDB, compares to branch port
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            alu_result.valid <= 1'b0;
            alu_branch.valid <= 1'b0;
        end else begin
            alu_result.valid <= alu_issue.valid && !is_branch && f.regwrite;
            alu_result.slot  <= alu_issue.slot;
            alu_result.rd    <= f.rd;
            alu_result.data  <= res;
            alu_branch.valid <= alu_issue.valid && is_branch;
            alu_branch.slot  <= alu_issue.slot;
            alu_branch.taken <= taken;
        end
    end

endmodule

`default_nettype wire

/* cdb_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_writeback (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire sched_pkg::cdb_t    alu_result,
    input  wire sched_pkg::cdb_t    mem_result,
    input  wire sched_pkg::branch_t alu_branch,
    output sched_pkg::cdb_t         cdb,
    output sched_pkg::branch_t      branch
);

    // Source picked for the bus this cycle
    sched_pkg::cdb_t pick;

    // Scheduler keeps these apart, memory wins on a clash
    assign pick = mem_result.valid ? mem_result : alu_result;

    ////////////////////////////////////////////////////////////////////////////
    // Writeback registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cdb.valid    <= 1'b0;
            branch.valid <= 1'b0;
        end else begin
            cdb          <= pick;
            // Branch outcome on its own port
            branch       <= alu_branch;
        end
    end

endmodule

`default_nettype wire

/* files.f */
sched_pkg.sv
rr_prioritizer.sv
issue_scheduler.sv
operand_collector.sv
alu_pipe.sv
mem_pipe.sv
cdb_writeback.sv
sched_top.sv
tb_clock_gen.sv
tb_sched_top.sv

/* issue_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_scheduler #(
    parameter int NUM_MEM_STAGES = 4
) (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic [sched_pkg::NUM_SLOTS-1:0] regwrite,
    input  wire logic [sched_pkg::NUM_SLOTS-1:0] alu_req,
    input  wire logic [sched_pkg::NUM_SLOTS-1:0] mem_req,
    output logic      [sched_pkg::NUM_SLOTS-1:0] alu_grt,
    output logic      [sched_pkg::NUM_SLOTS-1:0] mem_grt
);

    ////////////////////////////////////////////////////////////////////////////
    // Load tracking
    ////////////////////////////////////////////////////////////////////////////

    // One bit per cycle since grant, oldest bit at the top
    logic [NUM_MEM_STAGES-2:0] ld_track;
    // Register-writing load granted this cycle
    logic                      ld_in;

    assign ld_in = |(mem_grt & regwrite);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ld_track <= '0;
        end else begin
            ld_track <= {ld_track[NUM_MEM_STAGES-3:0], ld_in};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request qualification
    ////////////////////////////////////////////////////////////////////////////

    logic [sched_pkg::NUM_SLOTS-1:0] alu_req_q;
    logic [sched_pkg::NUM_SLOTS-1:0] mem_req_q;
    logic                            alu_wr_wait;

    // Oldest load hits the CDB together with an ALU issued now
    // Branch compares still go, they never touch the CDB
    assign alu_req_q = ld_track[NUM_MEM_STAGES-2] ? (alu_req & ~regwrite) : alu_req;

    // Some ALU writer is waiting
    assign alu_wr_wait = |(alu_req & regwrite);

    // Pipe full of loads and an ALU writer starving
    // hold new loads back so a hole opens, stores pass
    assign mem_req_q = (alu_wr_wait && (&ld_track)) ? (mem_req & ~regwrite) : mem_req;

    // ALU side arbiter
    rr_prioritizer #(
        .WIDTH (sched_pkg::NUM_SLOTS)
    ) u_alu_arb (
        .clk (clk),
        .rst (rst),
        .req (alu_req_q),
        .grt (alu_grt)
    );

    // Memory side arbiter
    rr_prioritizer #(
        .WIDTH (sched_pkg::NUM_SLOTS)
    ) u_mem_arb (
        .clk (clk),
        .rst (rst),
        .req (mem_req_q),
        .grt (mem_grt)
    );

endmodule

`default_nettype wire

/* mem_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_pipe #(
    parameter int NUM_MEM_STAGES = 4
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire sched_pkg::issue_t mem_issue,
    output sched_pkg::cdb_t        mem_result
);

    localparam int ADDR_W = 4;
    localparam int DEPTH  = 1 << ADDR_W;

    // Memory decoding of the word
    sched_pkg::mem_fields_t       f;
    logic [ADDR_W-1:0]            addr;
    logic                         is_load;
    logic                         is_store;
    // Data memory, 16 words
    logic [sched_pkg::DATA_W-1:0] dmem [DEPTH];
    // Load result pipeline, last entry feeds writeback
    sched_pkg::cdb_t              stage_q [NUM_MEM_STAGES];

    assign f    = mem_issue.instr.mem;
    // Base plus offset, wraps in 16 words
    assign addr = mem_issue.a[ADDR_W-1:0] + f.offset;

    assign is_store = mem_issue.valid && (f.op == sched_pkg::SW);
    // Only loads the scheduler tracks reach the CDB
    assign is_load  = mem_issue.valid && (f.op == sched_pkg::LW) && f.regwrite;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, memory access
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (is_store) begin
            dmem[addr] <= mem_issue.b;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stages 1..N, fixed latency shift
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int k = 0; k < NUM_MEM_STAGES; k++) begin
                stage_q[k].valid <= 1'b0;
            end
        end else begin
            // Read old word, one memory op per cycle so no write clash
            stage_q[0].valid <= is_load;
            stage_q[0].slot  <= mem_issue.slot;
            stage_q[0].rd    <= f.rd;
            stage_q[0].data  <= dmem[addr];
            for (int k = 1; k < NUM_MEM_STAGES; k++) begin
                stage_q[k] <= stage_q[k-1];
            end
        end
    end

    assign mem_result = stage_q[NUM_MEM_STAGES-1];

endmodule

`default_nettype wire

/* operand_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_collector (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    input  wire logic              [sched_pkg::NUM_SLOTS-1:0] disp_valid,
    input  wire sched_pkg::issue_t [sched_pkg::NUM_SLOTS-1:0] disp_instr,
    output logic                   [sched_pkg::NUM_SLOTS-1:0] slot_free,
    output logic                   [sched_pkg::NUM_SLOTS-1:0] alu_req,
    output logic                   [sched_pkg::NUM_SLOTS-1:0] mem_req,
    output logic                   [sched_pkg::NUM_SLOTS-1:0] regwrite,
    input  wire logic              [sched_pkg::NUM_SLOTS-1:0] alu_grt,
    input  wire logic              [sched_pkg::NUM_SLOTS-1:0] mem_grt,
    output sched_pkg::issue_t                                 alu_issue,
    output sched_pkg::issue_t                                 mem_issue
);

    // Slot occupied flags
    logic [sched_pkg::NUM_SLOTS-1:0] occ;
    // Held instruction and operands per slot
    sched_pkg::issue_t               held [sched_pkg::NUM_SLOTS];
    // Op class per slot
    logic [sched_pkg::NUM_SLOTS-1:0] is_mem;

    assign slot_free = ~occ;

    ////////////////////////////////////////////////////////////////////////////
    // Slot state
    ////////////////////////////////////////////////////////////////////////////

    // Grant frees at the next edge; dispatch fills a free slot
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            occ <= '0;
        end else begin
            for (int i = 0; i < sched_pkg::NUM_SLOTS; i++) begin
                if (alu_grt[i] || mem_grt[i]) begin
                    occ[i] <= 1'b0;
                end else if (disp_valid[i] && !occ[i]) begin
                    occ[i] <= 1'b1;
                end
            end
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        for (int i = 0; i < sched_pkg::NUM_SLOTS; i++) begin
            if (disp_valid[i] && !occ[i]) begin
                held[i] <= disp_instr[i];
            end
        end
    end

    // Requests from the op, op sits at the same bits in both views
    always_comb begin
        for (int i = 0; i < sched_pkg::NUM_SLOTS; i++) begin
            is_mem[i]   = held[i].instr.mem.op inside {sched_pkg::LW, sched_pkg::SW};
            alu_req[i]  = occ[i] && !is_mem[i];
            mem_req[i]  = occ[i] && is_mem[i];
            regwrite[i] = occ[i] && held[i].instr.alu.regwrite;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue muxes, grants are one-hot or zero
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_issue = '0;
        mem_issue = '0;
        for (int i = 0; i < sched_pkg::NUM_SLOTS; i++) begin
            if (alu_grt[i]) begin
                alu_issue       = held[i];
                alu_issue.valid = 1'b1;
                alu_issue.slot  = sched_pkg::SLOT_W'(i);
            end
            if (mem_grt[i]) begin
                mem_issue       = held[i];
                mem_issue.valid = 1'b1;
                mem_issue.slot  = sched_pkg::SLOT_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* rr_prioritizer.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_prioritizer #(
    parameter int WIDTH = 4
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic [WIDTH-1:0] req,
    output logic      [WIDTH-1:0] grt
);

    localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    // Highest-priority index this cycle
    logic [PTR_W-1:0] ptr;
    // Index of the winner, valid when found
    logic [PTR_W-1:0] win;
    logic             found;
    int               cand;

    // Scan from the pointer around the ring, first requester wins
    always_comb begin
        grt   = '0;
        win   = '0;
        found = 1'b0;
        cand  = 0;
        for (int i = 0; i < WIDTH; i++) begin
            cand = (int'(ptr) + i) % WIDTH;
            if (!found && req[cand]) begin
                found     = 1'b1;
                grt[cand] = 1'b1;
                win       = PTR_W'(cand);
            end
        end
    end

    // Pointer moves one past the winner, wraps at the top
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= (int'(win) == WIDTH - 1) ? '0 : win + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* sched_pkg.sv */
`default_nettype none

package sched_pkg;

    // Collector slots and datapath width
    parameter int NUM_SLOTS = 4;
    parameter int SLOT_W    = $clog2(NUM_SLOTS);
    parameter int DATA_W    = 16;

    // Four ALU ops, two branch compares, two memory ops
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        XOR,
        BEQ,
        BLT,
        LW,
        SW
    } op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word, 25 bits, two decodings
    ////////////////////////////////////////////////////////////////////////////

    // ALU view
    typedef struct packed {
        op_t         op;
        logic        regwrite;
        logic [3:0]  rd;
        logic [16:0] pad;
    } alu_fields_t;

    // Memory view, op/regwrite/rd at the same bits as the ALU view
    typedef struct packed {
        op_t         op;
        logic        regwrite;
        logic [3:0]  rd;
        logic [3:0]  offset;
        logic [12:0] pad;
    } mem_fields_t;

    typedef union packed {
        alu_fields_t alu;
        mem_fields_t mem;
    } instr_u;

    // Slot contents as handed to either pipe
    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] slot;
        instr_u            instr;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
    } issue_t;

    // Register writeback on the common data bus
    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] slot;
        logic [3:0]        rd;
        logic [DATA_W-1:0] data;
    } cdb_t;

    // Branch compare outcome
    typedef struct packed {
        logic              valid;
        logic [SLOT_W-1:0] slot;
        logic              taken;
    } branch_t;

endpackage

`default_nettype wire

/* sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_top #(
    parameter int NUM_MEM_STAGES = 4
) (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic              [sched_pkg::NUM_SLOTS-1:0] disp_valid,
    input  wire sched_pkg::issue_t [sched_pkg::NUM_SLOTS-1:0] disp_instr,
    output logic                   [sched_pkg::NUM_SLOTS-1:0] slot_free,
    output sched_pkg::cdb_t                                   cdb,
    output sched_pkg::branch_t                                branch
);

    // Collector to scheduler levels
    logic [sched_pkg::NUM_SLOTS-1:0] alu_req;
    logic [sched_pkg::NUM_SLOTS-1:0] mem_req;
    logic [sched_pkg::NUM_SLOTS-1:0] regwrite;
    // Same-cycle grants back
    logic [sched_pkg::NUM_SLOTS-1:0] alu_grt;
    logic [sched_pkg::NUM_SLOTS-1:0] mem_grt;
    // Pipe inputs and outputs
    sched_pkg::issue_t               alu_issue;
    sched_pkg::issue_t               mem_issue;
    sched_pkg::cdb_t                 alu_result;
    sched_pkg::cdb_t                 mem_result;
    sched_pkg::branch_t              alu_branch;

    operand_collector u_collector (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_instr (disp_instr),
        .slot_free  (slot_free),
        .alu_req    (alu_req),
        .mem_req    (mem_req),
        .regwrite   (regwrite),
        .alu_grt    (alu_grt),
        .mem_grt    (mem_grt),
        .alu_issue  (alu_issue),
        .mem_issue  (mem_issue)
    );

    // Load depth sets the collision window
    issue_scheduler #(
        .NUM_MEM_STAGES (NUM_MEM_STAGES)
    ) u_scheduler (
        .clk      (clk),
        .rst      (rst),
        .regwrite (regwrite),
        .alu_req  (alu_req),
        .mem_req  (mem_req),
        .alu_grt  (alu_grt),
        .mem_grt  (mem_grt)
    );

    alu_pipe u_alu (
        .clk        (clk),
        .rst        (rst),
        .alu_issue  (alu_issue),
        .alu_result (alu_result),
        .alu_branch (alu_branch)
    );

    mem_pipe #(
        .NUM_MEM_STAGES (NUM_MEM_STAGES)
    ) u_mem (
        .clk        (clk),
        .rst        (rst),
        .mem_issue  (mem_issue),
        .mem_result (mem_result)
    );

    cdb_writeback u_writeback (
        .clk        (clk),
        .rst        (rst),
        .alu_result (alu_result),
        .mem_result (mem_result),
        .alu_branch (alu_branch),
        .cdb        (cdb),
        .branch     (branch)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Active-low reset, released just after an edge
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sched_top;

    localparam int NUM_MEM_STAGES = 4;
    localparam int NS             = sched_pkg::NUM_SLOTS;
    localparam int DRAIN_CYC      = 200;
    localparam int MIX_CYCLES     = 1500;

    // Cycle bound per test
    localparam int T_RESET_CYC  = 100;
    localparam int T_ALU_CYC    = 400;
    localparam int T_BR_CYC     = 400;
    localparam int T_MEM_CYC    = 600;
    localparam int T_MIX_CYC    = 2500;
    localparam int WATCHDOG_CYC = T_RESET_CYC + T_ALU_CYC + T_BR_CYC + T_MEM_CYC + T_MIX_CYC;

    // Stimulus modes
    localparam int M_ARITH  = 0;
    localparam int M_BRANCH = 1;
    localparam int M_STORE  = 2;
    localparam int M_LOAD   = 3;
    localparam int M_MIXED  = 4;

    logic                              clk;
    logic                              rst;
    logic              [NS-1:0]        disp_valid;
    sched_pkg::issue_t [NS-1:0]        disp_instr;
    logic              [NS-1:0]        slot_free;
    sched_pkg::cdb_t                   cdb;
    sched_pkg::branch_t                branch;

    // Reference model state
    // CDB queue index is slot*2 + class, class 1 for loads (rd 8..15)
    logic [19:0]                  exp_cdb [2*NS][$];
    logic                         exp_br [NS][$];
    logic [sched_pkg::DATA_W-1:0] model_mem [16];
    logic [31:0]                  rng_state;
    int                           store_idx;
    int                           errors;
    int                           pass_cnt;
    int                           fail_cnt;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (16)
    ) u_clk (
        .clk (clk),
        .rst (rst)
    );

    sched_top #(
        .NUM_MEM_STAGES (NUM_MEM_STAGES)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_instr (disp_instr),
        .slot_free  (slot_free),
        .cdb        (cdb),
        .branch     (branch)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and model rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Arithmetic and loads write a register
    function automatic logic writes_reg(input sched_pkg::op_t op);
        return op inside {sched_pkg::ADD, sched_pkg::SUB, sched_pkg::AND, sched_pkg::XOR,
                          sched_pkg::LW};
    endfunction

    function automatic logic [15:0] alu_model(input sched_pkg::op_t op,
                                              input logic [15:0] a, input logic [15:0] b);
        case (op)
            sched_pkg::ADD: return a + b;
            sched_pkg::SUB: return a - b;
            sched_pkg::AND: return a & b;
            default:        return a ^ b;
        endcase
    endfunction

    // BEQ equal, BLT signed less than
    function automatic logic branch_model(input sched_pkg::op_t op,
                                          input logic [15:0] a, input logic [15:0] b);
        if (op == sched_pkg::BEQ) begin
            return a == b;
        end
        return $signed(a) < $signed(b);
    endfunction

    function automatic logic queues_empty();
        for (int i = 0; i < 2 * NS; i++) begin
            if (exp_cdb[i].size() != 0) return 1'b0;
        end
        for (int i = 0; i < NS; i++) begin
            if (exp_br[i].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Build one instruction for slot s and record its expected results
    task automatic make_dispatch(input int s, input int mode);
        logic [31:0]            r;
        logic [31:0]            r2;
        sched_pkg::op_t         op;
        sched_pkg::issue_t      ins;
        sched_pkg::alu_fields_t af;
        sched_pkg::mem_fields_t mf;
        logic [3:0]             rd;
        logic [3:0]             addr;
        logic [3:0]             off;
        logic [15:0]            a;
        logic [15:0]            b;
        r  = next_rand();
        r2 = next_rand();
        case (mode)
            M_ARITH:  op = sched_pkg::op_t'({1'b0, r[1:0]});
            M_BRANCH: op = r[0] ? sched_pkg::BLT : sched_pkg::BEQ;
            M_STORE:  op = sched_pkg::SW;
            M_LOAD:   op = sched_pkg::LW;
            default:  op = sched_pkg::op_t'(r[2:0]);
        endcase
        r    = next_rand();
        a    = r[15:0];
        b    = r[31:16];
        rd   = {1'b0, r2[2:0]};
        off  = r2[7:4];
        addr = '0;
        if (op == sched_pkg::SW) begin
            // Distinct words in the store test, upper half when mixed
            addr = (mode == M_STORE) ? 4'(store_idx) : {1'b1, r2[10:8]};
            store_idx++;
        end else if (op == sched_pkg::LW) begin
            addr = (mode == M_LOAD) ? r2[11:8] : {1'b0, r2[10:8]};
            rd   = {1'b1, r2[14:12]};
        end
        if (op inside {sched_pkg::LW, sched_pkg::SW}) begin
            a[3:0] = addr - off;
        end
        if (op == sched_pkg::BEQ && r2[15]) begin
            b = a;
        end
        ins       = '0;
        ins.valid = 1'b1;
        ins.slot  = sched_pkg::SLOT_W'(s);
        ins.a     = a;
        ins.b     = b;
        if (op inside {sched_pkg::LW, sched_pkg::SW}) begin
            mf             = '0;
            mf.op          = op;
            mf.regwrite    = writes_reg(op);
            mf.rd          = rd;
            mf.offset      = off;
            ins.instr.mem  = mf;
        end else begin
            af             = '0;
            af.op          = op;
            af.regwrite    = writes_reg(op);
            af.rd          = rd;
            ins.instr.alu  = af;
        end
        disp_instr[s] = ins;
        disp_valid[s] = 1'b1;
        case (op)
            sched_pkg::SW:  model_mem[addr] = b;
            sched_pkg::LW:  exp_cdb[s*2+1].push_back({rd, model_mem[addr]});
            sched_pkg::BEQ,
            sched_pkg::BLT: exp_br[s].push_back(branch_model(op, a, b));
            default:        exp_cdb[s*2].push_back({rd, alu_model(op, a, b)});
        endcase
    endtask

    // One cycle of dispatch to free slots, left counts what remains
    task automatic drive_cycle(input int mode, input bit fill, inout int left);
        logic [31:0] r;
        @(posedge clk);
        #2;
        disp_valid = '0;
        r = next_rand();
        for (int s = 0; s < NS; s++) begin
            if (slot_free[s] && left > 0 && (fill || r[s])) begin
                make_dispatch(s, mode);
                left--;
            end
        end
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        #2;
        disp_valid = '0;
    endtask

    task automatic run_count(input int mode, input int count, input int bound);
        int left;
        int cyc;
        left = count;
        cyc  = 0;
        while (left > 0 && cyc < bound) begin
            drive_cycle(mode, 1'b0, left);
            cyc++;
        end
        if (left > 0) begin
            $display("Only %0d of %0d dispatches accepted in %0d cycles", count - left,
                     count, bound);
            errors++;
        end
        idle_inputs();
    endtask

    // Every free slot refilled each cycle
    task automatic run_fill(input int cycles);
        int left;
        left = cycles * NS;
        repeat (cycles) drive_cycle(M_MIXED, 1'b1, left);
        idle_inputs();
    endtask

    // Slots free within bound, then every result seen
    task automatic wait_drain(input int bound);
        int cyc;
        cyc = 0;
        while (slot_free !== {NS{1'b1}} && cyc < bound) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (slot_free !== {NS{1'b1}}) begin
            $display("Slots still busy %0d cycles after the last dispatch", bound);
            errors++;
        end
        cyc = 0;
        while (!queues_empty() && cyc < NUM_MEM_STAGES + 4) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!queues_empty()) begin
            $display("Expected results never appeared after the pipes drained");
            errors++;
            for (int i = 0; i < 2 * NS; i++) exp_cdb[i].delete();
            for (int i = 0; i < NS; i++) exp_br[i].delete();
        end
    endtask

    task automatic end_test(input string name, input int err0);
        if (errors == err0) begin
            pass_cnt++;
            $display("Test %s passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s failed with %0d errors", name, errors - err0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor, samples mid-cycle
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin : result_monitor
        int          idx;
        logic [19:0] e;
        if (rst === 1'b1) begin
            if (cdb.valid === 1'b1) begin
                idx = int'(cdb.slot) * 2 + int'(cdb.rd[3]);
                if (exp_cdb[idx].size() == 0) begin
                    $display("Unexpected CDB entry at %0t from slot %0d rd %0d", $time,
                             cdb.slot, cdb.rd);
                    errors++;
                end else begin
                    e = exp_cdb[idx].pop_front();
                    check_value(cdb.rd, e[19:16], "cdb.rd");
                    check_value(cdb.data, e[15:0], "cdb.data");
                end
            end
            if (branch.valid === 1'b1) begin
                if (exp_br[branch.slot].size() == 0) begin
                    $display("Unexpected branch outcome at %0t from slot %0d", $time,
                             branch.slot);
                    errors++;
                end else begin
                    check_value(branch.taken, exp_br[branch.slot].pop_front(), "branch.taken");
                end
            end
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYC);
        $display(">>> FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int err0;
        disp_valid = '0;
        disp_instr = '0;
        rng_state  = 32'd7793;
        store_idx  = 0;
        errors     = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        for (int i = 0; i < 16; i++) model_mem[i] = '0;

        // Reset state, outputs quiet before any dispatch
        err0 = errors;
        @(posedge clk);
        while (rst !== 1'b1) begin
            @(negedge clk);
            check_value(cdb.valid, 32'h0, "cdb.valid in reset");
            check_value(branch.valid, 32'h0, "branch.valid in reset");
        end
        repeat (8) begin
            @(negedge clk);
            check_value(slot_free, 32'hF, "slot_free after reset");
            check_value(cdb.valid, 32'h0, "cdb.valid after reset");
            check_value(branch.valid, 32'h0, "branch.valid after reset");
        end
        end_test("reset", err0);

        err0 = errors;
        run_count(M_ARITH, 48, T_ALU_CYC - DRAIN_CYC);
        wait_drain(DRAIN_CYC);
        end_test("alu", err0);

        err0 = errors;
        run_count(M_BRANCH, 48, T_BR_CYC - DRAIN_CYC);
        wait_drain(DRAIN_CYC);
        end_test("branch", err0);

        // Stores first, then loads once memory is settled
        err0 = errors;
        store_idx = 0;
        run_count(M_STORE, 16, 100);
        wait_drain(DRAIN_CYC);
        repeat (NUM_MEM_STAGES + 2) @(posedge clk);
        run_count(M_LOAD, 24, 100);
        wait_drain(DRAIN_CYC);
        end_test("memory", err0);

        err0 = errors;
        run_fill(MIX_CYCLES);
        wait_drain(DRAIN_CYC);
        end_test("mixed", err0);

        $display("Tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
